/* sim.f */
source/rename_pkg.sv
source/map_table.sv
source/arch_map.sv
source/free_list.sv
source/reorder_buffer.sv
source/rename_core.sv
dv/tb_clock.sv
dv/rename_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the rename core testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module rename_tb -f sim.f -o rename_sim

# the simulation exits nonzero on failure, the log decides the result
./obj_dir/rename_sim > sim.log 2>&1 || true
cat sim.log

if grep -q '^\*\*\* PASSED \*\*\*$' sim.log; then
    exit 0
fi
exit 1

/* dv/rename_tb.sv */
////////////////////
// rename core testbench
// lfsr stimulus, reference model of maps, ready bits, free list and rob
// per cycle checks at the falling edge, bounded waits
////////////////////
`timescale 1ns/1ps

module rename_tb;
    import rename_pkg::*;

    localparam int num_phys      = 44;  // 12 free regs, runs dry before the rob fills
    localparam int rob_depth     = 16;
    localparam int fl_depth      = num_phys - NUM_ARCH;
    localparam int phys_slots    = 1 << PHYS_IDX_W;
    localparam int run_cycles    = 3000;
    localparam int reset_limit   = 100;
    localparam int hold_limit    = 200;
    localparam int drain_limit   = 1000;
    localparam int mode_drain    = 4;
    localparam int mode_directed = 5;

    // one in-flight instruction of the model
    typedef struct packed {
        rob_idx_t  rob_idx;
        logic      has_dest;
        arch_reg_t dest_ar;
        phys_reg_t new_pr;
        phys_reg_t old_pr;
        logic      done;
        logic      mispredict;
    } flight_t;

    logic          clock;
    logic          rst;
    dispatch_req_t req;
    logic          dispatch_ready;
    rename_rsp_t   rsp;
    complete_t     complete;
    retire_t       retire;

    tb_clock #(.reset_cycles(16)) u_clock (.clock(clock), .rst(rst));

    rename_core #(.num_phys(num_phys), .rob_depth(rob_depth)) dut (
        .clock         (clock),
        .rst           (rst),
        .req           (req),
        .dispatch_ready(dispatch_ready),
        .rsp           (rsp),
        .complete      (complete),
        .retire        (retire)
    );

    ////////////////////
    // model state
    ////////////////////
    phys_reg_t     spec_map   [NUM_ARCH];
    phys_reg_t     arch_map_m [NUM_ARCH];
    logic          ready_m    [phys_slots];
    phys_reg_t     fl_ring    [fl_depth];
    int            fl_head;
    int            fl_tail;
    int            fl_count;
    int            rob_tail;
    flight_t       inflight [$];   // oldest first

    logic [31:0]   lfsr;
    dispatch_req_t cur_req;        // what was driven this cycle
    complete_t     cur_cpl;
    logic          held;           // refused request, offered again
    int            hold_cycles;
    logic          after_recover;
    int            directed_idx;
    int            recoveries;
    int            full_stalls;
    int            empty_stalls;
    int            retired;

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    function automatic int unsigned take_bits(input int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    task automatic stop_run();
        $display("*** FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_error(input string what);
        $display("%s", what);
        stop_run();
    endtask

    task automatic check_eq(input string name, input int unsigned exp, input int unsigned act);
        assert (exp == act) else begin
            $display("Fail %s expected %0d actual %0d", name, exp, act);
            stop_run();
        end
    endtask

    // state right after reset
    task automatic model_reset();
        for (int i = 0; i < NUM_ARCH; i++) begin
            spec_map[i]   = phys_reg_t'(i);
            arch_map_m[i] = phys_reg_t'(i);
        end
        for (int i = 0; i < phys_slots; i++) begin
            ready_m[i] = 1'b1;
        end
        for (int i = 0; i < fl_depth; i++) begin
            fl_ring[i] = phys_reg_t'(NUM_ARCH + i);
        end
        fl_head  = 0;
        fl_tail  = 0;
        fl_count = fl_depth;
        rob_tail = 0;
        inflight.delete();
    endtask

    ////////////////////
    // stimulus, driven at the rising edge
    ////////////////////
    task automatic pick_stimulus(input int mode);
        int   busy [$];
        int   pick;
        logic cpl_hit;

        if (!held) begin
            cur_req = '0;
            if (mode == mode_directed || (mode != mode_drain && take_bits(2) != 0)) begin
                cur_req.valid = 1'b1;
                case (mode)
                    mode_directed: cur_req.has_dest = 1'b0;
                    0:             cur_req.has_dest = (take_bits(2) == 0);  // rob fills
                    1:             cur_req.has_dest = (take_bits(3) != 0);  // free list drains
                    default:       cur_req.has_dest = (take_bits(2) != 0);
                endcase
                cur_req.dest_ar = arch_reg_t'(take_bits(ARCH_IDX_W));
                cur_req.src1_ar = arch_reg_t'(take_bits(ARCH_IDX_W));
                cur_req.src2_ar = arch_reg_t'(take_bits(ARCH_IDX_W));
            end
        end

        // completion of one busy entry, model already holds post edge state
        cur_cpl = '0;
        foreach (inflight[i]) begin
            if (!inflight[i].done) begin
                busy.push_back(i);
            end
        end
        case (mode)
            mode_directed: cpl_hit = 1'b0;
            mode_drain:    cpl_hit = 1'b1;
            0, 1:          cpl_hit = (take_bits(3) == 0);
            default:       cpl_hit = (take_bits(1) == 1);
        endcase
        if (cpl_hit && busy.size() > 0) begin
            pick               = busy[take_bits(4) % busy.size()];
            cur_cpl.valid      = 1'b1;
            cur_cpl.rob_idx    = inflight[pick].rob_idx;
            cur_cpl.mispredict = (mode != mode_drain) && (take_bits(3) == 0);  // 1 in 8
        end

        req      <= cur_req;
        complete <= cur_cpl;
    endtask

    ////////////////////
    // checks at the falling edge, then model steps over the next edge
    ////////////////////
    task automatic check_cycle(input logic directed);
        logic      exp_full;
        logic      fl_empty;
        logic      head_done;
        logic      exp_recover;
        logic      exp_ready;
        logic      accepted;
        phys_reg_t exp_dest;
        flight_t   ent;
        int        slot;

        exp_full    = inflight.size() == rob_depth;
        fl_empty    = fl_count == 0;
        head_done   = inflight.size() > 0 && inflight[0].done;
        exp_recover = head_done && inflight[0].mispredict;
        exp_ready   = !exp_full && !(cur_req.has_dest && fl_empty) && !exp_recover;
        accepted    = cur_req.valid && exp_ready;
        exp_dest    = cur_req.has_dest ? fl_ring[fl_head] : '0;

        check_eq("dispatch_ready", exp_ready, dispatch_ready);
        check_eq("retire_valid", head_done, retire.valid);
        if (head_done) begin
            ent = inflight[0];
            check_eq("retire_has_dest", ent.has_dest, retire.has_dest);
            check_eq("retire_new_pr", ent.new_pr, retire.new_pr);
            check_eq("retire_mispredict", ent.mispredict, retire.mispredict);
            if (ent.has_dest) begin
                check_eq("retire_dest_ar", ent.dest_ar, retire.dest_ar);
                check_eq("retire_old_pr", ent.old_pr, retire.old_pr);
            end
        end
        if (cur_req.valid) begin
            check_eq("rename_src1_pr", spec_map[cur_req.src1_ar], rsp.src1_pr);
            check_eq("rename_src1_ready", ready_m[spec_map[cur_req.src1_ar]], rsp.src1_ready);
            check_eq("rename_src2_pr", spec_map[cur_req.src2_ar], rsp.src2_pr);
            check_eq("rename_src2_ready", ready_m[spec_map[cur_req.src2_ar]], rsp.src2_ready);
        end
        if (accepted) begin
            check_eq("rename_dest_pr", exp_dest, rsp.dest_pr);
            check_eq("rename_rob_idx", rob_tail, rsp.rob_idx);
            if (directed) begin
                // identity map, all ready
                check_eq("reset_src1_pr", cur_req.src1_ar, rsp.src1_pr);
                check_eq("reset_src2_pr", cur_req.src2_ar, rsp.src2_pr);
                check_eq("reset_src1_ready", 1, rsp.src1_ready);
                check_eq("reset_src2_ready", 1, rsp.src2_ready);
                check_eq("reset_rob_idx", directed_idx, rsp.rob_idx);
            end
            if (after_recover) begin
                check_eq("recover_src1_pr", arch_map_m[cur_req.src1_ar], rsp.src1_pr);
                check_eq("recover_src2_pr", arch_map_m[cur_req.src2_ar], rsp.src2_pr);
                check_eq("recover_src1_ready", 1, rsp.src1_ready);
                check_eq("recover_src2_ready", 1, rsp.src2_ready);
                after_recover = 1'b0;
            end
        end

        // stall bookkeeping and request hold
        if (cur_req.valid && !exp_ready) begin
            if (exp_full) begin
                full_stalls++;
            end else if (cur_req.has_dest && fl_empty && !exp_recover) begin
                empty_stalls++;
            end
        end
        held = cur_req.valid && !accepted;
        if (held) begin
            hold_cycles++;
            if (hold_cycles > hold_limit) begin
                report_error("dispatch request was refused for too many cycles in a row");
            end
        end else begin
            hold_cycles = 0;
        end

        // retire frees the old register at the tail
        if (head_done) begin
            ent = inflight.pop_front();
            retired++;
            if (ent.has_dest) begin
                arch_map_m[ent.dest_ar] = ent.new_pr;
                fl_ring[fl_tail]        = ent.old_pr;
                fl_tail                 = (fl_tail + 1) % fl_depth;
                fl_count++;
            end
        end

        if (exp_recover) begin
            recoveries++;
            after_recover = 1'b1;
            for (int i = 0; i < NUM_ARCH; i++) begin
                spec_map[i] = arch_map_m[i];
            end
            for (int i = 0; i < phys_slots; i++) begin
                ready_m[i] = 1'b1;
            end
            inflight.delete();   // flush, completion this cycle is lost too
            rob_tail = 0;
            fl_head  = fl_tail;  // rollback, list full again
            fl_count = fl_depth;
        end else begin
            if (cur_cpl.valid) begin
                slot = -1;
                foreach (inflight[i]) begin
                    if (inflight[i].rob_idx == cur_cpl.rob_idx) begin
                        slot = i;
                    end
                end
                if (slot < 0) begin
                    report_error("completion was driven for an entry that is not in flight");
                end
                ent            = inflight[slot];
                ent.done       = 1'b1;
                ent.mispredict = cur_cpl.mispredict;
                inflight[slot] = ent;
                if (ent.has_dest) begin
                    ready_m[ent.new_pr] = 1'b1;  // wakeup before alloc clear
                end
            end
            if (accepted) begin
                ent.rob_idx    = rob_idx_t'(rob_tail);
                ent.has_dest   = cur_req.has_dest;
                ent.dest_ar    = cur_req.dest_ar;
                ent.new_pr     = exp_dest;
                ent.old_pr     = spec_map[cur_req.dest_ar];
                ent.done       = 1'b0;
                ent.mispredict = 1'b0;
                if (cur_req.has_dest) begin
                    spec_map[cur_req.dest_ar] = exp_dest;
                    ready_m[exp_dest]         = 1'b0;
                    fl_head                   = (fl_head + 1) % fl_depth;
                    fl_count--;
                end
                rob_tail = (rob_tail + 1) % rob_depth;
                inflight.push_back(ent);
            end
        end
    endtask

    ////////////////////
    // sequence
    ////////////////////
    initial begin
        int n;

        req           = '0;
        complete      = '0;
        lfsr          = 32'd92533;
        cur_req       = '0;
        cur_cpl       = '0;
        held          = 1'b0;
        hold_cycles   = 0;
        after_recover = 1'b0;
        directed_idx  = 0;
        recoveries    = 0;
        full_stalls   = 0;
        empty_stalls  = 0;
        retired       = 0;
        model_reset();

        // wait for reset release
        n = 0;
        @(negedge clock);
        while (rst && n < reset_limit) begin
            @(negedge clock);
            n++;
        end
        if (rst) begin
            report_error("reset was never released");
        end

        // no dest dispatches straight after reset
        for (int k = 0; k < 8; k++) begin
            @(posedge clock);
            pick_stimulus(mode_directed);
            @(negedge clock);
            directed_idx = k;
            check_cycle(1'b1);
        end

        // random traffic, mode changes every 64 cycles
        for (int cyc = 0; cyc < run_cycles; cyc++) begin
            @(posedge clock);
            pick_stimulus((cyc / 64) % 4);
            @(negedge clock);
            check_cycle(1'b0);
        end

        // drain, no new requests
        n = 0;
        while ((inflight.size() > 0 || held) && n < drain_limit) begin
            @(posedge clock);
            pick_stimulus(mode_drain);
            @(negedge clock);
            check_cycle(1'b0);
            n++;
        end
        if (inflight.size() > 0 || held) begin
            report_error("in-flight instructions did not drain before the timeout");
        end

        $display("retired %0d, recoveries %0d, rob full stalls %0d, free list stalls %0d",
                 retired, recoveries, full_stalls, empty_stalls);
        if (recoveries > 0 && full_stalls > 0 && empty_stalls > 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            report_error("run never reached a recovery, a full rob and an empty free list");
        end
    end

endmodule

/* dv/tb_clock.sv */
////////////////////
// testbench clock and reset
// 10 ns clock, rst high for the first reset_cycles edges
////////////////////
`timescale 1ns/1ps

module tb_clock #(
    parameter int half_period  = 5,
    parameter int reset_cycles = 16
) (
    output logic clock,
    output logic rst
);

    initial begin
        clock = 1'b0;
        forever #half_period clock = ~clock;
    end

    // sync reset, released by nba on the last reset edge
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clock);
        rst <= 1'b0;
    end

endmodule

/* source/rename_core.sv */
////////////////////
// rename core top level
// map table, arch map, free list and rob wired together
////////////////////
`timescale 1ns/1ps

module rename_core #(
    parameter int num_phys  = 64,  // at most 128
    parameter int rob_depth = 16   // power of two, at most 32
) (
    input  logic                     clock,
    input  logic                     rst,
    input  rename_pkg::dispatch_req_t req,
    output logic                     dispatch_ready,
    output rename_pkg::rename_rsp_t  rsp,
    input  rename_pkg::complete_t    complete,
    output rename_pkg::retire_t      retire
);
    import rename_pkg::*;

    logic                     alloc;            // pop a free register
    logic                     free_empty;
    phys_reg_t                free_pr;
    phys_reg_t                old_pr;           // current mapping of dest_ar
    phys_reg_t                src1_pr;
    phys_reg_t                src2_pr;
    logic                     src1_ready;
    logic                     src2_ready;
    rob_idx_t                 rob_idx;
    logic                     ready_set_valid;
    phys_reg_t                ready_set;
    logic                     recover;          // mispredict retiring
    phys_reg_t [NUM_ARCH-1:0] arch_table;       // committed map incl this retire

    // rename response, same cycle as the request
    assign rsp = '{
        src1_pr:    src1_pr,
        src1_ready: src1_ready,
        src2_pr:    src2_pr,
        src2_ready: src2_ready,
        dest_pr:    req.has_dest ? free_pr : '0,
        rob_idx:    rob_idx
    };

    ////////////////////
    // instances
    ////////////////////
    map_table u_map_table (
        .clock          (clock),
        .rst            (rst),
        .alloc          (alloc),
        .req            (req),
        .new_pr         (free_pr),
        .src1_pr        (src1_pr),
        .src2_pr        (src2_pr),
        .old_pr         (old_pr),
        .src1_ready     (src1_ready),
        .src2_ready     (src2_ready),
        .ready_set_valid(ready_set_valid),
        .ready_set      (ready_set),
        .recover        (recover),
        .arch_table     (arch_table)
    );

    arch_map u_arch_map (
        .clock     (clock),
        .rst       (rst),
        .retire    (retire),
        .arch_table(arch_table)
    );

    free_list #(.num_phys(num_phys)) u_free_list (
        .clock  (clock),
        .rst    (rst),
        .alloc  (alloc),
        .free_pr(free_pr),
        .empty  (free_empty),
        .push   (retire.valid & retire.has_dest),  // old mapping goes back
        .push_pr(retire.old_pr),
        .recover(recover)
    );

    reorder_buffer #(.rob_depth(rob_depth)) u_reorder_buffer (
        .clock          (clock),
        .rst            (rst),
        .req            (req),
        .free_empty     (free_empty),
        .free_pr        (free_pr),
        .old_pr         (old_pr),
        .dispatch_ready (dispatch_ready),
        .alloc          (alloc),
        .rob_idx        (rob_idx),
        .complete       (complete),
        .ready_set_valid(ready_set_valid),
        .ready_set      (ready_set),
        .retire         (retire),
        .recover        (recover)
    );

endmodule

/* source/reorder_buffer.sv */
////////////////////
// in-order reorder buffer
// dispatch accept, completion marking, head retire and mispredict flush
////////////////////
`timescale 1ns/1ps

module reorder_buffer #(
    parameter int rob_depth = 16   // power of two
) (
    input  logic                      clock,
    input  logic                      rst,
    input  rename_pkg::dispatch_req_t req,
    input  logic                      free_empty,
    input  rename_pkg::phys_reg_t     free_pr,
    input  rename_pkg::phys_reg_t     old_pr,
    output logic                      dispatch_ready,
    output logic                      alloc,
    output rename_pkg::rob_idx_t      rob_idx,
    input  rename_pkg::complete_t     complete,
    output logic                      ready_set_valid,
    output rename_pkg::phys_reg_t     ready_set,
    output rename_pkg::retire_t       retire,
    output logic                      recover
);
    import rename_pkg::*;

    localparam int ptr_w = $clog2(rob_depth);

    // payload of one slot
    typedef struct packed {
        logic      has_dest;
        arch_reg_t dest_ar;
        phys_reg_t new_pr;
        phys_reg_t old_pr;
        logic      mispredict;
    } rob_entry_t;

    rob_state_e        state [rob_depth];
    rob_entry_t        entry [rob_depth];
    rob_entry_t        head_entry;
    logic [ptr_w-1:0]  head;
    logic [ptr_w-1:0]  tail;
    logic [ptr_w-1:0]  cpl_ptr;
    logic [ptr_w:0]    count;
    logic              full;
    logic              accept;

    ////////////////////
    // dispatch side
    ////////////////////
    assign full           = (count == (ptr_w + 1)'(rob_depth));
    assign dispatch_ready = !full && !(req.has_dest && free_empty) && !recover;
    assign accept         = req.valid & dispatch_ready;
    assign alloc          = accept & req.has_dest;   // free list pop
    assign rob_idx        = rob_idx_t'(tail);

    // completion forwards the produced register to the map table
    assign cpl_ptr         = complete.rob_idx[ptr_w-1:0];
    assign ready_set_valid = complete.valid & entry[cpl_ptr].has_dest;
    assign ready_set       = entry[cpl_ptr].new_pr;

    ////////////////////
    // retire side
    ////////////////////
    assign head_entry = entry[head];
    assign retire = '{
        valid:      state[head] == rob_done,
        has_dest:   head_entry.has_dest,
        dest_ar:    head_entry.dest_ar,
        new_pr:     head_entry.new_pr,
        old_pr:     head_entry.old_pr,
        mispredict: head_entry.mispredict
    };
    assign recover = retire.valid & head_entry.mispredict;  // flush at this edge

    always_ff @(posedge clock) begin
        if (rst || recover) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < rob_depth; i++) begin
                state[i] <= rob_empty;
            end
        end else begin
            if (accept) begin
                state[tail] <= rob_busy;
                tail        <= tail + 1'b1;
            end
            if (complete.valid) begin
                state[cpl_ptr] <= rob_done;
            end
            if (retire.valid) begin
                state[head] <= rob_empty;
                head        <= head + 1'b1;
            end
            count <= count + (ptr_w + 1)'(accept) - (ptr_w + 1)'(retire.valid);
        end
    end

    // payload, only meaningful while the slot is not empty
    always_ff @(posedge clock) begin
        if (accept) begin
            entry[tail] <= '{
                has_dest:   req.has_dest,
                dest_ar:    req.dest_ar,
                new_pr:     req.has_dest ? free_pr : '0,
                old_pr:     old_pr,
                mispredict: 1'b0
            };
        end
        if (complete.valid) begin
            entry[cpl_ptr].mispredict <= complete.mispredict;
        end
    end

    a_complete_busy : assert property (
        @(posedge clock) disable iff (rst) complete.valid |-> state[cpl_ptr] == rob_busy
    );

endmodule

/* source/free_list.sv */
////////////////////
// circular free list of physical registers
// pop at head on dispatch, push at tail on retire, head rollback on recovery
////////////////////
`timescale 1ns/1ps

module free_list #(
    parameter int num_phys = 64
) (
    input  logic                  clock,
    input  logic                  rst,
    input  logic                  alloc,
    output rename_pkg::phys_reg_t free_pr,
    output logic                  empty,
    input  logic                  push,
    input  rename_pkg::phys_reg_t push_pr,
    input  logic                  recover
);
    import rename_pkg::*;

    localparam int fl_depth = num_phys - NUM_ARCH;  // regs not held by the arch map
    localparam int fl_idx_w = $clog2(fl_depth);
    localparam logic [fl_idx_w:0] fl_full = (fl_idx_w + 1)'(fl_depth);

    phys_reg_t            entries [fl_depth];
    logic [fl_idx_w-1:0]  head;
    logic [fl_idx_w-1:0]  tail;
    logic [fl_idx_w-1:0]  tail_next;
    logic [fl_idx_w:0]    count;

    // wraps at fl_depth, not always a power of two
    function automatic logic [fl_idx_w-1:0] next_ptr(input logic [fl_idx_w-1:0] p);
        if (p == fl_idx_w'(fl_depth - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign free_pr   = entries[head];
    assign empty     = (count == '0);
    assign tail_next = push ? next_ptr(tail) : tail;

    ////////////////////
    // pointers
    ////////////////////
    always_ff @(posedge clock) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= fl_full;
        end else if (recover) begin
            // popped slots since the tail are the flushed in-flight regs
            head  <= tail_next;
            tail  <= tail_next;
            count <= fl_full;
        end else begin
            if (alloc) begin
                head <= next_ptr(head);   // entry stays, rollback reuses it
            end
            tail <= tail_next;
            case ({alloc, push})
                2'b10:   count <= count - 1'b1;
                2'b01:   count <= count + 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

    // contents start as 32 .. num_phys-1
    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < fl_depth; i++) begin
                entries[i] <= phys_reg_t'(NUM_ARCH + i);
            end
        end else if (push) begin
            entries[tail] <= push_pr;
        end
    end

    a_no_alloc_empty : assert property (@(posedge clock) disable iff (rst) alloc |-> !empty);
    a_no_push_full   : assert property (@(posedge clock) disable iff (rst) push |-> count != fl_full);

endmodule

/* source/arch_map.sv */
////////////////////
// committed rename map, written at retire
////////////////////
`timescale 1ns/1ps

module arch_map (
    input  logic                                           clock,
    input  logic                                           rst,
    input  rename_pkg::retire_t                            retire,
    output rename_pkg::phys_reg_t [rename_pkg::NUM_ARCH-1:0] arch_table
);
    import rename_pkg::*;

    phys_reg_t [NUM_ARCH-1:0] committed;

    // next committed map, seen by the map table on a recovery edge
    always_comb begin
        arch_table = committed;
        if (retire.valid && retire.has_dest) begin
            arch_table[retire.dest_ar] = retire.new_pr;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < NUM_ARCH; i++) begin
                committed[i] <= phys_reg_t'(i);  // ar i -> pr i
            end
        end else begin
            committed <= arch_table;
        end
    end

endmodule

/* source/map_table.sv */
////////////////////
// speculative rename map with per physical register ready bits
// source lookup, dest allocation, recovery load from arch map
////////////////////
`timescale 1ns/1ps

module map_table (
    input  logic                                           clock,
    input  logic                                           rst,
    input  logic                                           alloc,
    input  rename_pkg::dispatch_req_t                      req,
    input  rename_pkg::phys_reg_t                          new_pr,
    output rename_pkg::phys_reg_t                          src1_pr,
    output rename_pkg::phys_reg_t                          src2_pr,
    output rename_pkg::phys_reg_t                          old_pr,
    output logic                                           src1_ready,
    output logic                                           src2_ready,
    input  logic                                           ready_set_valid,
    input  rename_pkg::phys_reg_t                          ready_set,
    input  logic                                           recover,
    input  rename_pkg::phys_reg_t [rename_pkg::NUM_ARCH-1:0] arch_table
);
    import rename_pkg::*;

    localparam int phys_slots = 1 << PHYS_IDX_W;  // covers any num_phys

    phys_reg_t [NUM_ARCH-1:0] spec_map;
    logic [phys_slots-1:0]    ready;

    ////////////////////
    // lookup
    ////////////////////
    // state before the edge, no bypass of same cycle completion
    assign src1_pr    = spec_map[req.src1_ar];
    assign src2_pr    = spec_map[req.src2_ar];
    assign old_pr     = spec_map[req.dest_ar];  // stored in rob, freed at retire
    assign src1_ready = ready[src1_pr];
    assign src2_ready = ready[src2_pr];

    ////////////////////
    // update
    ////////////////////
    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < NUM_ARCH; i++) begin
                spec_map[i] <= phys_reg_t'(i);  // identity map
            end
            ready <= '1;
        end else if (recover) begin
            // committed state, everything in it has been written back
            spec_map <= arch_table;
            ready    <= '1;
        end else begin
            if (ready_set_valid) begin
                ready[ready_set] <= 1'b1;       // completion wakeup
            end
            if (alloc) begin
                spec_map[req.dest_ar] <= new_pr;
                ready[new_pr]         <= 1'b0;  // not produced yet
            end
        end
    end

    // rob refuses dispatch while a mispredict retires
    a_no_alloc_on_recover : assert property (
        @(posedge clock) disable iff (rst) !(alloc && recover)
    );

endmodule

/* source/rename_pkg.sv */
////////////////////
// shared widths and index types for the rename core
// rob entry state enum, dispatch, rename, completion and retire structs
////////////////////
package rename_pkg;

    ////////////////////
    // widths
    ////////////////////
    localparam int NUM_ARCH   = 32;
    localparam int ARCH_IDX_W = 5;
    localparam int PHYS_IDX_W = 7;   // num_phys up to 128
    localparam int ROB_IDX_W  = 5;   // rob_depth power of two, up to 32

    typedef logic [ARCH_IDX_W-1:0] arch_reg_t;
    typedef logic [PHYS_IDX_W-1:0] phys_reg_t;
    typedef logic [ROB_IDX_W-1:0]  rob_idx_t;

    // lifetime of one rob slot
    typedef enum logic [1:0] {
        rob_empty = 2'd0,
        rob_busy  = 2'd1,   // dispatched, waiting on completion
        rob_done  = 2'd2    // completed, waiting for retire
    } rob_state_e;

    ////////////////////
    // packets
    ////////////////////
    typedef struct packed {
        logic      valid;
        logic      has_dest;
        arch_reg_t dest_ar;
        arch_reg_t src1_ar;
        arch_reg_t src2_ar;
    } dispatch_req_t;          // 17 bits

    typedef struct packed {
        phys_reg_t src1_pr;
        logic      src1_ready;
        phys_reg_t src2_pr;
        logic      src2_ready;
        phys_reg_t dest_pr;    // zero when no destination
        rob_idx_t  rob_idx;
    } rename_rsp_t;            // 28 bits

    typedef struct packed {
        logic     valid;
        rob_idx_t rob_idx;
        logic     mispredict;
    } complete_t;              // 7 bits

    typedef struct packed {
        logic      valid;
        logic      has_dest;
        arch_reg_t dest_ar;
        phys_reg_t new_pr;
        phys_reg_t old_pr;     // freed at retire
        logic      mispredict;
    } retire_t;                // 22 bits

endpackage
